//--- logic/coreConsts.svh
// Core constants shared by the RV32I execution core: widths, opcodes and latency.
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path and register file size.
`define CORE_XLEN 32
`define CORE_NREGS 32

// Major opcodes of the supported instruction groups.
`define CORE_OP_IMM 7'b0010011
`define CORE_OP_REG 7'b0110011
`define CORE_OP_LUI 7'b0110111
`define CORE_OP_BRANCH 7'b1100011

// funct7 values that select the base and the alternate ALU operation.
`define CORE_F7_BASE 7'b0000000
`define CORE_F7_ALT 7'b0100000

// Cycles from the sampling edge to the result pulse at the outputs.
`define CORE_EXEC_LAT 2

`endif

//--- logic/corePkg.sv
// Core types: operand words, register indices, instruction fields and decoded control.
`include "coreConsts.svh"

package corePkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [$clog2(`CORE_NREGS)-1:0] regIdx_t;
  typedef logic [`CORE_XLEN-1:0] pc_t;

  typedef struct packed {
    logic [6:0] funct7;
    regIdx_t rs2;
    regIdx_t rs1;
    logic [2:0] funct3;
    regIdx_t rd;
    logic [6:0] opcode;
  } instr_t;

  // NONE_TYPE is zero so that a cleared control word means no operation.
  typedef enum logic [2:0] {NONE_TYPE, R_TYPE, I_TYPE, U_TYPE, B_TYPE} encoding_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR,
    ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU, ALU_LUI
  } aluOp_e;

  typedef enum logic [2:0] {BEQ, BNE, BLT, BGE, BLTU, BGEU} branch_e;

  typedef struct packed {
    encoding_e encoding;
    logic regWrite;
    logic aluSrc; // Second operand is the immediate.
    logic isBranch;
    aluOp_e aluOp;
    branch_e branchType;
  } control_t;

endpackage

//--- logic/coreIfs.sv
// Core interfaces: register read port, decode stage output and execute stage output.
`timescale 1ns/1ns

interface regReadBus;
  corePkg::regIdx_t rs1;
  corePkg::regIdx_t rs2;
  corePkg::word_t rs1Data;
  corePkg::word_t rs2Data;

  modport dec (output rs1, rs2, input rs1Data, rs2Data);
  modport rf (input rs1, rs2, output rs1Data, rs2Data);
endinterface

interface decodeBus;
  logic valid;
  corePkg::control_t ctrl;
  corePkg::pc_t pc;
  corePkg::word_t opA;
  corePkg::word_t opB;
  corePkg::word_t imm;
  corePkg::regIdx_t rd;

  modport dec (output valid, ctrl, pc, opA, opB, imm, rd);
  modport exe (input valid, ctrl, pc, opA, opB, imm, rd);
endinterface

interface execBus;
  logic fwdValid; // Result computed this cycle, not yet registered.
  corePkg::regIdx_t fwdRd;
  corePkg::word_t fwdData;
  logic wbValid;
  corePkg::regIdx_t wbRd;
  corePkg::word_t wbData;

  modport exe (output fwdValid, fwdRd, fwdData, wbValid, wbRd, wbData);
  modport fwd (input fwdValid, fwdRd, fwdData);
  modport wb (input wbValid, wbRd, wbData);
endinterface

//--- logic/instrDecode.sv
// Instruction decoder: control decode, immediates, operand read with forwarding, decode register.
`timescale 1ns/1ns
`include "coreConsts.svh"

module instrDecode (
  input logic clk,
  input logic rst,
  input logic instrValid,
  input corePkg::instr_t instr,
  input corePkg::pc_t pc,
  regReadBus.dec rf,
  execBus.fwd fwd,
  decodeBus.dec dec,
  output logic illegalInstr
);

  corePkg::control_t ctrlNext;
  logic illegalNext;
  logic isReg;
  logic isImm;
  logic altFunct;
  corePkg::word_t raw;
  corePkg::word_t immNext;
  corePkg::word_t opANext;
  corePkg::word_t opBNext;
  logic [`CORE_EXEC_LAT-1:0] illegalPipe;

  assign raw = instr;
  assign isReg = instr.opcode == `CORE_OP_REG;
  assign isImm = instr.opcode == `CORE_OP_IMM;
  assign altFunct = instr.funct7 == `CORE_F7_ALT;

  always_comb begin
    ctrlNext = '0;
    illegalNext = 1'b0;
    case (instr.opcode)
      `CORE_OP_IMM: begin
        ctrlNext.encoding = corePkg::I_TYPE;
        ctrlNext.regWrite = 1'b1;
        ctrlNext.aluSrc = 1'b1;
      end
      `CORE_OP_REG: begin
        ctrlNext.encoding = corePkg::R_TYPE;
        ctrlNext.regWrite = 1'b1;
      end
      `CORE_OP_LUI: begin
        ctrlNext.encoding = corePkg::U_TYPE;
        ctrlNext.regWrite = 1'b1;
        ctrlNext.aluSrc = 1'b1;
        ctrlNext.aluOp = corePkg::ALU_LUI;
      end
      `CORE_OP_BRANCH: begin
        ctrlNext.encoding = corePkg::B_TYPE;
        ctrlNext.isBranch = 1'b1;
        case (instr.funct3)
          3'b000: ctrlNext.branchType = corePkg::BEQ;
          3'b001: ctrlNext.branchType = corePkg::BNE;
          3'b100: ctrlNext.branchType = corePkg::BLT;
          3'b101: ctrlNext.branchType = corePkg::BGE;
          3'b110: ctrlNext.branchType = corePkg::BLTU;
          3'b111: ctrlNext.branchType = corePkg::BGEU;
          default: illegalNext = 1'b1;
        endcase
      end
      default: illegalNext = 1'b1;
    endcase

    // Register and immediate forms share the funct3 mapping.
    if (isReg || isImm) begin
      case (instr.funct3)
        3'b000: ctrlNext.aluOp = (isReg && altFunct) ? corePkg::ALU_SUB : corePkg::ALU_ADD;
        3'b001: ctrlNext.aluOp = corePkg::ALU_SLL;
        3'b010: ctrlNext.aluOp = corePkg::ALU_SLT;
        3'b011: ctrlNext.aluOp = corePkg::ALU_SLTU;
        3'b100: ctrlNext.aluOp = corePkg::ALU_XOR;
        3'b101: ctrlNext.aluOp = altFunct ? corePkg::ALU_SRA : corePkg::ALU_SRL;
        3'b110: ctrlNext.aluOp = corePkg::ALU_OR;
        default: ctrlNext.aluOp = corePkg::ALU_AND;
      endcase
    end

    // Only ADD/SUB and SRL/SRA have an alternate funct7.
    if (isReg && !(instr.funct7 == `CORE_F7_BASE ||
                   (altFunct && instr.funct3 inside {3'b000, 3'b101}))) begin
      illegalNext = 1'b1;
    end
    if (isImm && instr.funct3 == 3'b001 && instr.funct7 != `CORE_F7_BASE) begin
      illegalNext = 1'b1;
    end
    if (isImm && instr.funct3 == 3'b101 && !(instr.funct7 == `CORE_F7_BASE || altFunct)) begin
      illegalNext = 1'b1;
    end

    if (illegalNext) begin
      ctrlNext = '0;
    end
  end

  always_comb begin
    case (ctrlNext.encoding)
      corePkg::I_TYPE: immNext = {{20{raw[31]}}, raw[31:20]};
      corePkg::U_TYPE: immNext = {raw[31:12], 12'b0};
      corePkg::B_TYPE: immNext = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
      default: immNext = '0;
    endcase
  end

  assign rf.rs1 = instr.rs1;
  assign rf.rs2 = instr.rs2;

  // The instruction one ahead is still in execute. Older ones come through the register file.
  assign opANext = (fwd.fwdValid && fwd.fwdRd == instr.rs1) ? fwd.fwdData : rf.rs1Data;
  assign opBNext = (fwd.fwdValid && fwd.fwdRd == instr.rs2) ? fwd.fwdData : rf.rs2Data;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
      illegalPipe <= '0;
    end else begin
      dec.valid <= instrValid && !illegalNext;
      illegalPipe <= {illegalPipe[`CORE_EXEC_LAT-2:0], instrValid && illegalNext};
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      dec.ctrl <= ctrlNext;
      dec.pc <= pc;
      dec.opA <= opANext;
      dec.opB <= opBNext;
      dec.imm <= immNext;
      dec.rd <= instr.rd;
    end
  end

  assign illegalInstr = illegalPipe[`CORE_EXEC_LAT-1]; // Lines up with the execute outputs.

  validClearedAfterReset: assert property (@(posedge clk) rst |=> !dec.valid);

endmodule

//--- logic/aluExecute.sv
// Execute stage: ALU, branch condition and target, and the execute pipeline register.
`timescale 1ns/1ns
`include "coreConsts.svh"

module aluExecute (
  input logic clk,
  input logic rst,
  decodeBus.exe dec,
  execBus.exe exe,
  output logic branchValid,
  output logic branchTaken,
  output corePkg::pc_t branchTarget
);

  corePkg::word_t srcB;
  corePkg::word_t aluResult;
  logic [4:0] shamt;
  logic taken;
  logic isBranchNow;
  corePkg::pc_t target;

  assign srcB = dec.ctrl.aluSrc ? dec.imm : dec.opB;
  assign shamt = srcB[4:0]; // RV32I shifts by at most 31.

  always_comb begin
    case (dec.ctrl.aluOp)
      corePkg::ALU_ADD: aluResult = dec.opA + srcB;
      corePkg::ALU_SUB: aluResult = dec.opA - srcB;
      corePkg::ALU_SLL: aluResult = dec.opA << shamt;
      corePkg::ALU_SRL: aluResult = dec.opA >> shamt;
      corePkg::ALU_SRA: aluResult = $signed(dec.opA) >>> shamt;
      corePkg::ALU_XOR: aluResult = dec.opA ^ srcB;
      corePkg::ALU_OR: aluResult = dec.opA | srcB;
      corePkg::ALU_AND: aluResult = dec.opA & srcB;
      corePkg::ALU_SLT: begin
        aluResult = {{(`CORE_XLEN-1){1'b0}}, $signed(dec.opA) < $signed(srcB)};
      end
      corePkg::ALU_SLTU: aluResult = {{(`CORE_XLEN-1){1'b0}}, dec.opA < srcB};
      corePkg::ALU_LUI: aluResult = dec.imm;
      default: aluResult = '0;
    endcase
  end

  // Branches always compare the two register operands.
  always_comb begin
    case (dec.ctrl.branchType)
      corePkg::BEQ: taken = dec.opA == dec.opB;
      corePkg::BNE: taken = dec.opA != dec.opB;
      corePkg::BLT: taken = $signed(dec.opA) < $signed(dec.opB);
      corePkg::BGE: taken = $signed(dec.opA) >= $signed(dec.opB);
      corePkg::BLTU: taken = dec.opA < dec.opB;
      corePkg::BGEU: taken = dec.opA >= dec.opB;
      default: taken = 1'b0;
    endcase
  end

  assign target = dec.pc + dec.imm;
  assign isBranchNow = dec.valid && dec.ctrl.isBranch;

  assign exe.fwdValid = dec.valid && dec.ctrl.regWrite && dec.rd != '0;
  assign exe.fwdRd = dec.rd;
  assign exe.fwdData = aluResult;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe.wbValid <= 1'b0;
      branchValid <= 1'b0;
      branchTaken <= 1'b0;
      branchTarget <= '0;
    end else begin
      exe.wbValid <= exe.fwdValid;
      branchValid <= isBranchNow;
      branchTaken <= isBranchNow && taken;
      if (isBranchNow) begin
        branchTarget <= target;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exe.fwdValid) begin
      exe.wbRd <= dec.rd;
      exe.wbData <= aluResult;
    end
  end

  // The decoder never sets regWrite and isBranch together.
  noWbWithBranch: assert property (
    @(posedge clk) disable iff (rst) !(exe.wbValid && branchValid)
  );

endmodule

//--- logic/resultWriteback.sv
// Result stage: register file with write-through read ports and the write-back report.
`timescale 1ns/1ns
`include "coreConsts.svh"

module resultWriteback (
  input logic clk,
  input logic rst,
  execBus.wb exe,
  regReadBus.rf rf,
  output logic wbValid,
  output corePkg::regIdx_t wbRd,
  output corePkg::word_t wbData
);

  corePkg::word_t regs [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (exe.wbValid) begin
      regs[exe.wbRd] <= exe.wbData;
    end
  end

  // A write landing at this edge is returned to the instruction two behind it.
  assign rf.rs1Data = (rf.rs1 == '0) ? '0 :
                      (exe.wbValid && exe.wbRd == rf.rs1) ? exe.wbData : regs[rf.rs1];
  assign rf.rs2Data = (rf.rs2 == '0) ? '0 :
                      (exe.wbValid && exe.wbRd == rf.rs2) ? exe.wbData : regs[rf.rs2];

  assign wbValid = exe.wbValid;
  assign wbRd = exe.wbRd;
  assign wbData = exe.wbData;

  // Execute filters rd of zero, so x0 keeps its reset value.
  noWriteToZero: assert property (
    @(posedge clk) disable iff (rst) exe.wbValid |-> exe.wbRd != '0
  );

endmodule

//--- logic/miniCore.sv
// Top level of the RV32I execution core: decode, execute and write-back stages.
`timescale 1ns/1ns
`include "coreConsts.svh"

module miniCore (
  input logic clk,
  input logic rst,
  input logic instrValid,
  input logic [`CORE_XLEN-1:0] instr,
  input corePkg::pc_t pc,
  output logic wbValid,
  output corePkg::regIdx_t wbRd,
  output corePkg::word_t wbData,
  output logic branchValid,
  output logic branchTaken,
  output corePkg::pc_t branchTarget,
  output logic illegalInstr
);

  regReadBus rfBus ();
  decodeBus decBus ();
  execBus exBus ();

  instrDecode uDecode (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .instr(corePkg::instr_t'(instr)),
    .pc(pc),
    .rf(rfBus.dec),
    .fwd(exBus.fwd),
    .dec(decBus.dec),
    .illegalInstr(illegalInstr)
  );

  aluExecute uExecute (
    .clk(clk),
    .rst(rst),
    .dec(decBus.exe),
    .exe(exBus.exe),
    .branchValid(branchValid),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget)
  );

  resultWriteback uWriteback (
    .clk(clk),
    .rst(rst),
    .exe(exBus.wb),
    .rf(rfBus.rf),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData)
  );

endmodule

//--- verification/miniCoreChecker.sv
// Output checker for the RV32I execution core with an in-order architectural model.
`timescale 1ns/1ns
`include "coreConsts.svh"

module miniCoreChecker (
  input logic clk,
  input logic rst,
  input logic instrValid,
  input logic [`CORE_XLEN-1:0] instr,
  input corePkg::pc_t pc,
  input logic wbValid,
  input corePkg::regIdx_t wbRd,
  input corePkg::word_t wbData,
  input logic branchValid,
  input logic branchTaken,
  input corePkg::pc_t branchTarget,
  input logic illegalInstr,
  output int valueErrors,
  output int pulseErrors,
  output int accepted,
  output int pending
);

  typedef struct packed {
    logic wbValid;
    corePkg::regIdx_t wbRd;
    corePkg::word_t wbData;
    logic brValid;
    logic brTaken;
    corePkg::pc_t brTarget;
    logic illegal;
  } expect_t;

  corePkg::word_t model [`CORE_NREGS];
  expect_t expQ [$];

  initial begin
    valueErrors = 0;
    pulseErrors = 0;
    accepted = 0;
    pending = 0;
  end

  function automatic corePkg::word_t aluRef(input logic [2:0] f3, input logic alt,
                                            input corePkg::word_t a, input corePkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes one accepted instruction against the model and returns its expected outputs.
  task automatic executeModel(input corePkg::instr_t ins, input corePkg::pc_t pcIn,
                              output expect_t e);
    logic [31:0] raw;
    corePkg::word_t a;
    corePkg::word_t b;
    corePkg::word_t immI;
    corePkg::word_t immB;
    corePkg::word_t res;
    logic writes;
    logic alt;
    raw = ins;
    e = '0;
    a = model[ins.rs1];
    b = model[ins.rs2];
    immI = {{20{raw[31]}}, raw[31:20]};
    immB = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    alt = ins.funct7 == `CORE_F7_ALT;
    writes = 1'b0;
    res = '0;
    case (ins.opcode)
      `CORE_OP_REG: begin
        if (ins.funct7 == `CORE_F7_BASE || (alt && ins.funct3 inside {3'd0, 3'd5})) begin
          res = aluRef(ins.funct3, alt, a, b);
          writes = 1'b1;
        end else begin
          e.illegal = 1'b1;
        end
      end
      `CORE_OP_IMM: begin
        if (ins.funct3 == 3'd1 && ins.funct7 != `CORE_F7_BASE) begin
          e.illegal = 1'b1;
        end else if (ins.funct3 == 3'd5 && !(alt || ins.funct7 == `CORE_F7_BASE)) begin
          e.illegal = 1'b1;
        end else begin
          res = aluRef(ins.funct3, alt && ins.funct3 == 3'd5, a, immI);
          writes = 1'b1;
        end
      end
      `CORE_OP_LUI: begin
        res = {raw[31:12], 12'b0};
        writes = 1'b1;
      end
      `CORE_OP_BRANCH: begin
        e.brValid = 1'b1;
        case (ins.funct3)
          3'd0: e.brTaken = a == b;
          3'd1: e.brTaken = a != b;
          3'd4: e.brTaken = $signed(a) < $signed(b);
          3'd5: e.brTaken = $signed(a) >= $signed(b);
          3'd6: e.brTaken = a < b;
          3'd7: e.brTaken = a >= b;
          default: begin
            e.brValid = 1'b0;
            e.illegal = 1'b1;
          end
        endcase
        e.brTarget = pcIn + immB;
      end
      default: e.illegal = 1'b1;
    endcase
    if (writes && ins.rd != '0) begin
      model[ins.rd] = res; // x0 is never written, so it keeps reading as zero.
      e.wbValid = 1'b1;
      e.wbRd = ins.rd;
      e.wbData = res;
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR %s expected 0x%h actual 0x%h at %0t ns", name, expected, actual, $time);
    end
  endtask

  task automatic reportPulse(input string what, input logic expected);
    pulseErrors++;
    $display("%s %s pulse at %0t ns.", expected ? "Missing" : "Unexpected", what, $time);
  endtask

  task automatic compareOutputs(input expect_t e);
    if (wbValid !== e.wbValid) begin
      reportPulse("write-back", e.wbValid);
    end else if (e.wbValid) begin
      checkValue("wbRd", e.wbRd, wbRd);
      checkValue("wbData", e.wbData, wbData);
    end
    if (branchValid !== e.brValid) begin
      reportPulse("branch", e.brValid);
    end else if (e.brValid) begin
      checkValue("branchTaken", e.brTaken, branchTaken);
      checkValue("branchTarget", e.brTarget, branchTarget);
    end else if (branchTaken !== 1'b0) begin
      pulseErrors++;
      $display("branchTaken is high without a branch report at %0t ns.", $time);
    end
    if (illegalInstr !== e.illegal) begin
      reportPulse("illegal-instruction", e.illegal);
    end
  endtask

  // Inputs change just after the rising edge, so both sides are read at the falling edge.
  always @(negedge clk) begin
    expect_t cur;
    expect_t due;
    if (rst) begin
      expQ.delete();
      for (int i = 0; i < `CORE_EXEC_LAT; i++) begin
        expQ.push_back('0); // No pulse may follow reset until an instruction is accepted.
      end
      foreach (model[i]) begin
        model[i] = '0;
      end
    end else begin
      cur = '0;
      if (instrValid) begin
        executeModel(instr, pc, cur);
        accepted++;
      end
      expQ.push_back(cur);
      due = expQ.pop_front();
      compareOutputs(due);
    end
    pending = 0;
    foreach (expQ[i]) begin
      if (expQ[i].wbValid || expQ[i].brValid || expQ[i].illegal) begin
        pending++;
      end
    end
  end

endmodule

//--- verification/miniCoreTb.sv
// Testbench for the RV32I execution core that drives a seeded random instruction stream.
`timescale 1ns/1ns
`include "coreConsts.svh"

module miniCoreTb;

  localparam int NumInstr = 2000;
  localparam int DriveDelay = 1;
  localparam int DrainLimit = 20;

  logic clk;
  logic rst;
  logic instrValid;
  logic [`CORE_XLEN-1:0] instr;
  corePkg::pc_t pc;
  logic wbValid;
  corePkg::regIdx_t wbRd;
  corePkg::word_t wbData;
  logic branchValid;
  logic branchTaken;
  corePkg::pc_t branchTarget;
  logic illegalInstr;
  int valueErrors;
  int pulseErrors;
  int accepted;
  int pending;
  int seed;
  int sent;
  int waited;
  logic timedOut;

  miniCore u_dut (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .instr(instr),
    .pc(pc),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData),
    .branchValid(branchValid),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .illegalInstr(illegalInstr)
  );

  miniCoreChecker uChecker (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .instr(instr),
    .pc(pc),
    .wbValid(wbValid),
    .wbRd(wbRd),
    .wbData(wbData),
    .branchValid(branchValid),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .illegalInstr(illegalInstr),
    .valueErrors(valueErrors),
    .pulseErrors(pulseErrors),
    .accepted(accepted),
    .pending(pending)
  );

  always #10 clk = ~clk;

  // Low registers are picked more often so that a result is read again soon after it is written.
  function automatic corePkg::regIdx_t pickReg();
    if ($urandom_range(0, 3) == 0) begin
      return corePkg::regIdx_t'($urandom_range(0, 31));
    end
    return corePkg::regIdx_t'($urandom_range(0, 7));
  endfunction

  function automatic corePkg::instr_t randomInstr();
    corePkg::instr_t ins;
    int kind;
    kind = $urandom_range(0, 99);
    ins = corePkg::instr_t'($urandom());
    ins.rd = pickReg();
    ins.rs1 = pickReg();
    ins.rs2 = pickReg();
    if (kind < 2) begin
      ins.opcode = 7'($urandom_range(0, 127));
      if (ins.opcode inside {`CORE_OP_IMM, `CORE_OP_REG, `CORE_OP_LUI, `CORE_OP_BRANCH}) begin
        ins.opcode = ins.opcode ^ 7'b1000000; // Lands on an opcode the core does not support.
      end
    end else if (kind < 36) begin
      ins.opcode = `CORE_OP_REG;
      ins.funct7 = `CORE_F7_BASE;
      if ($urandom_range(0, 2) == 0) begin
        ins.funct7 = `CORE_F7_ALT;
        // Now and then the alternate funct7 stays on another funct3, which is illegal.
        if ($urandom_range(0, 7) != 0) begin
          ins.funct3 = $urandom_range(0, 1) ? 3'd0 : 3'd5;
        end
      end
      if ($urandom_range(0, 49) == 0) begin
        ins.funct7 = 7'($urandom());
      end
    end else if (kind < 70) begin
      ins.opcode = `CORE_OP_IMM;
      if (ins.funct3 == 3'd1) begin
        ins.funct7 = ($urandom_range(0, 7) == 0) ? `CORE_F7_ALT : `CORE_F7_BASE;
      end else if (ins.funct3 == 3'd5) begin
        ins.funct7 = $urandom_range(0, 1) ? `CORE_F7_ALT : `CORE_F7_BASE;
      end
      if ($urandom_range(0, 49) == 0) begin
        ins.funct7 = 7'($urandom());
      end
    end else if (kind < 78) begin
      ins.opcode = `CORE_OP_LUI;
    end else begin
      ins.opcode = `CORE_OP_BRANCH;
      ins.funct3 = 3'($urandom_range(0, 5));
      if (ins.funct3 > 3'd1) begin
        ins.funct3 = ins.funct3 + 3'd2; // Skips the two unused conditions.
      end
    end
    return ins;
  endfunction

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    pc = '0;
    timedOut = 1'b0;
    seed = $urandom(98);
    repeat (3) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    pc = $urandom() & 32'hffff_fffc;
    sent = 0;
    while (sent < NumInstr) begin
      @(posedge clk);
      #DriveDelay;
      if ($urandom_range(0, 3) != 0) begin
        instrValid = 1'b1;
        instr = randomInstr();
        pc = pc + 32'd4;
        sent++;
      end else begin
        instrValid = 1'b0;
        instr = $urandom(); // Ignored by the DUT while instrValid is low.
      end
    end
    @(posedge clk);
    #DriveDelay;
    instrValid = 1'b0;

    waited = 0;
    while (pending != 0 && waited < DrainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      timedOut = 1'b1;
      $display("Timed out with %0d expected outputs still outstanding.", pending);
    end
    repeat (`CORE_EXEC_LAT) @(posedge clk);

    $display("Checked %0d instructions: %0d value errors, %0d pulse errors.",
             accepted, valueErrors, pulseErrors);
    if (timedOut || valueErrors != 0 || pulseErrors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/corePkg.sv
logic/coreIfs.sv
logic/instrDecode.sv
logic/aluExecute.sv
logic/resultWriteback.sv
logic/miniCore.sv
verification/miniCoreChecker.sv
verification/miniCoreTb.sv

//--- Bender.yml
package:
  name: mini_core

sources:
  - target: any(rtl, test)
    include_dirs:
      - logic
    files:
      - logic/corePkg.sv
      - logic/coreIfs.sv
      - logic/instrDecode.sv
      - logic/aluExecute.sv
      - logic/resultWriteback.sv
      - logic/miniCore.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/miniCoreChecker.sv
      - verification/miniCoreTb.sv
